/* logic/zip_dbg_pkg.sv */
// Shared types and constants for the debug front end of the soft core.
// Import with a wildcard in any module that needs the widths or structs.

package zip_dbg_pkg;

	////////////////////////////////////////////////////////////
	// Widths with a meaning
	////////////////////////////////////////////////////////////

	// Debug bus word and its byte strobe
	typedef logic [31:0]	dbg_word_t;
	typedef logic [3:0]	dbg_strb_t;
	// One of 32 CPU registers
	typedef logic [4:0]	reg_idx_t;
	// Condition codes from the core
	typedef logic [2:0]	cpu_cc_t;

	////////////////////////////////////////////////////////////
	// Control word bit positions
	////////////////////////////////////////////////////////////

	localparam int RESET_BIT	= 6;
	localparam int STEP_BIT		= 8;
	localparam int HALT_BIT		= 10;
	localparam int CLEAR_CACHE_BIT	= 11;

	// Word address bit that selects the register space
	localparam int REG_SEL_BIT	= 5;

	// Every debug access completes as OKAY
	localparam logic [1:0] RESP_OKAY = 2'b00;

	// Register write with a one-cycle valid
	typedef struct packed {
		logic		valid;
		reg_idx_t	idx;
		dbg_word_t	data;
	} dbg_wr_t;

	// Control word write with the strobe as given on the bus
	typedef struct packed {
		logic		valid;
		dbg_strb_t	strb;
		dbg_word_t	data;
	} dbg_cmd_t;

endpackage

/* logic/dbg_skid.sv */
// One-entry skid buffer for an AXI-lite address or data channel.
// Passes data straight through when empty; upstream ready is a register.
`timescale 1ns/1ps

module dbg_skid #(
	parameter int DW = 8
)(
	input  logic		S_AXI_ACLK,
	input  logic		S_AXI_ARESETN,
	// Upstream side
	input  logic		i_valid,
	output logic		o_ready,
	input  logic [DW-1:0]	i_data,
	// Downstream side
	output logic		o_valid,
	input  logic		i_ready,
	output logic [DW-1:0]	o_data
);

	// Held word, only meaningful while r_valid is set
	logic		r_valid;
	logic [DW-1:0]	r_data;

	////////////////////////////////////////////////////////////
	// Holding register
	////////////////////////////////////////////////////////////

	// Fill when a word arrives and downstream refuses it
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (i_valid && o_ready && o_valid && !i_ready)
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	// Capture whatever sits on the input while empty
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
			r_data <= i_data;
	end

	////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////

	// Ready drops only once the buffer holds a word
	assign o_ready = !r_valid;

	// Held word has priority, it came first
	assign o_valid = i_valid || r_valid;
	assign o_data  = r_valid ? r_data : i_data;

endmodule

/* logic/dbg_axil_slave.sv */
// AXI-lite debug slave: joins AW and W, splits control and register space,
// holds register writes across core stalls and answers reads.
`timescale 1ns/1ps

module dbg_axil_slave
	import zip_dbg_pkg::*;
#(
	parameter int C_DBG_ADDR_WIDTH = 8
)(
	input  logic				S_AXI_ACLK,
	input  logic				S_AXI_ARESETN,
	// AXI-lite debug port
	input  logic				S_DBG_AWVALID,
	output logic				S_DBG_AWREADY,
	input  logic [C_DBG_ADDR_WIDTH-1:0]	S_DBG_AWADDR,
	input  logic [2:0]			S_DBG_AWPROT,
	input  logic				S_DBG_WVALID,
	output logic				S_DBG_WREADY,
	input  dbg_word_t			S_DBG_WDATA,
	input  dbg_strb_t			S_DBG_WSTRB,
	output logic				S_DBG_BVALID,
	input  logic				S_DBG_BREADY,
	output logic [1:0]			S_DBG_BRESP,
	input  logic				S_DBG_ARVALID,
	output logic				S_DBG_ARREADY,
	input  logic [C_DBG_ADDR_WIDTH-1:0]	S_DBG_ARADDR,
	input  logic [2:0]			S_DBG_ARPROT,
	output logic				S_DBG_RVALID,
	input  logic				S_DBG_RREADY,
	output dbg_word_t			S_DBG_RDATA,
	output logic [1:0]			S_DBG_RRESP,
	// Core and control side
	input  logic				i_cpu_stall,
	input  dbg_word_t			i_status,
	input  dbg_word_t			i_reg_rdata,
	output reg_idx_t			o_reg_ridx,
	output dbg_wr_t				o_reg_wr,
	output logic				o_reg_wr_accept,
	output dbg_cmd_t			o_cmd
);

	// Byte address bits below the word
	localparam int DBGLSB = $clog2($bits(dbg_word_t) / 8);
	localparam int WAW    = C_DBG_ADDR_WIDTH - DBGLSB;

	logic			awskd_valid, wskd_valid, arskd_valid;
	logic [WAW-1:0]		awskd_addr, arskd_addr;
	dbg_word_t		wskd_data;
	dbg_strb_t		wskd_strb;
	logic			write_ready, read_ready;
	// Register write waiting for the core
	logic			wr_pend;
	reg_idx_t		wr_idx;
	dbg_word_t		wr_data;
	// Bank read one cycle from RDATA
	logic			rd_inflight;

	////////////////////////////////////////////////////////////
	// Write path
	////////////////////////////////////////////////////////////

	dbg_skid #(.DW(WAW)) u_awskd (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(S_DBG_AWVALID), .o_ready(S_DBG_AWREADY),
		.i_data(S_DBG_AWADDR[C_DBG_ADDR_WIDTH-1:DBGLSB]),
		.o_valid(awskd_valid), .i_ready(write_ready), .o_data(awskd_addr)
	);

	dbg_skid #(.DW($bits(dbg_word_t) + $bits(dbg_strb_t))) u_wskd (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(S_DBG_WVALID), .o_ready(S_DBG_WREADY),
		.i_data({ S_DBG_WDATA, S_DBG_WSTRB }),
		.o_valid(wskd_valid), .i_ready(write_ready),
		.o_data({ wskd_data, wskd_strb })
	);

	// Both halves present, B free, nothing still held for the core
	assign write_ready = awskd_valid && wskd_valid && !wr_pend
			&& (!S_DBG_BVALID || S_DBG_BREADY);

	// Register space write with at least one byte lane
	assign o_reg_wr_accept = write_ready && awskd_addr[REG_SEL_BIT] && (|wskd_strb);

	// Control word goes straight out as a strobe
	assign o_cmd = '{valid: write_ready && !awskd_addr[REG_SEL_BIT],
			strb: wskd_strb, data: wskd_data};

	// Pending flag, cleared on the first non-stalled cycle
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			wr_pend <= 1'b0;
		else if (o_reg_wr_accept)
			wr_pend <= 1'b1;
		else if (!i_cpu_stall)
			wr_pend <= 1'b0;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_reg_wr_accept)
		begin
			wr_idx  <= awskd_addr[4:0];
			wr_data <= wskd_data;
		end
	end

	// Bank sees the write exactly once
	assign o_reg_wr = '{valid: wr_pend && !i_cpu_stall, idx: wr_idx, data: wr_data};

	// B channel, one response per accepted write
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			S_DBG_BVALID <= 1'b0;
		else if (write_ready)
			S_DBG_BVALID <= 1'b1;
		else if (S_DBG_BREADY)
			S_DBG_BVALID <= 1'b0;
	end

	assign S_DBG_BRESP = RESP_OKAY;

	////////////////////////////////////////////////////////////
	// Read path
	////////////////////////////////////////////////////////////

	dbg_skid #(.DW(WAW)) u_arskd (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(S_DBG_ARVALID), .o_ready(S_DBG_ARREADY),
		.i_data(S_DBG_ARADDR[C_DBG_ADDR_WIDTH-1:DBGLSB]),
		.o_valid(arskd_valid), .i_ready(read_ready), .o_data(arskd_addr)
	);

	// Writes drain before any read is taken
	assign read_ready = arskd_valid && !rd_inflight && !wr_pend
			&& (!S_DBG_RVALID || S_DBG_RREADY);

	// Bank registers this index every cycle
	assign o_reg_ridx = arskd_addr[4:0];

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rd_inflight <= 1'b0;
		else
			rd_inflight <= read_ready && arskd_addr[REG_SEL_BIT];
	end

	// Status answers next cycle, registers one cycle later
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			S_DBG_RVALID <= 1'b0;
		else if (!S_DBG_RVALID || S_DBG_RREADY)
			S_DBG_RVALID <= (read_ready && !arskd_addr[REG_SEL_BIT]) || rd_inflight;
	end

	// Holds while RVALID waits
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_DBG_RVALID || S_DBG_RREADY)
			S_DBG_RDATA <= rd_inflight ? i_reg_rdata : i_status;
	end

	assign S_DBG_RRESP = RESP_OKAY;

endmodule

/* logic/cpu_ctrl.sv */
// Core control: reset hold after power-up, halt, step, clear-cache and
// reset commands from the debug port, and the debug status word.
`timescale 1ns/1ps

module cpu_ctrl
	import zip_dbg_pkg::*;
#(
	parameter int	RESET_DURATION	= 10,
	parameter bit	START_HALTED	= 1'b0
)(
	input  logic		S_AXI_ACLK,
	input  logic		S_AXI_ARESETN,
	input  dbg_cmd_t	i_cmd,
	input  logic		i_reg_wr_accept,
	// From the core
	input  logic		i_cpu_reset,
	input  logic		i_cpu_stall,
	input  logic		i_cpu_break,
	input  logic		i_interrupt,
	input  cpu_cc_t		i_cpu_cc,
	output dbg_word_t	o_status,
	// To the core
	output logic		o_cmd_reset,
	output logic		o_cmd_halt,
	output logic		o_cmd_step,
	output logic		o_cmd_clear_cache,
	output logic		o_halted
);

	// Counter wide enough for the full hold
	localparam int CW = (RESET_DURATION > 0) ? $clog2(RESET_DURATION + 1) : 1;

	logic [CW-1:0]	reset_cnt;
	// Command byte lanes
	logic		cmd_lo, cmd_hi;

	assign cmd_lo = i_cmd.valid && i_cmd.strb[0];
	assign cmd_hi = i_cmd.valid && i_cmd.strb[1];

	////////////////////////////////////////////////////////////
	// Reset hold
	////////////////////////////////////////////////////////////

	// Reloads on either reset, counts down to zero
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			reset_cnt <= CW'(RESET_DURATION);
		else if (reset_cnt != 0)
			reset_cnt <= reset_cnt - 1'b1;
	end

	// High for RESET_DURATION cycles, plus one-cycle command pulses
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			o_cmd_reset <= 1'b1;
		else
			o_cmd_reset <= (reset_cnt > 1)
				|| (i_cpu_break && !START_HALTED)
				|| (cmd_lo && i_cmd.data[RESET_BIT]);
	end

	////////////////////////////////////////////////////////////
	// Halt
	////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			o_cmd_halt <= START_HALTED;
		else if (o_cmd_reset && START_HALTED)
			o_cmd_halt <= START_HALTED;
		else
		begin
			// Release, or run for a single step
			if (cmd_hi && (!i_cmd.data[HALT_BIT] || i_cmd.data[STEP_BIT]))
				o_cmd_halt <= 1'b0;
			// Reasons to halt, these win over a release
			if (i_cpu_break && START_HALTED)
				o_cmd_halt <= 1'b1;
			if (cmd_hi && i_cmd.data[HALT_BIT] && !i_cmd.data[STEP_BIT])
				o_cmd_halt <= 1'b1;
			if (cmd_hi && i_cmd.data[CLEAR_CACHE_BIT])
				o_cmd_halt <= 1'b1;
			// Core must sit still while a register changes
			if (i_reg_wr_accept)
				o_cmd_halt <= 1'b1;
			// Step or cache clear just finished
			if ((o_cmd_step || o_cmd_clear_cache) && !i_cpu_stall)
				o_cmd_halt <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Step and clear-cache
	////////////////////////////////////////////////////////////

	// Held until the core takes a non-stalled cycle
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			o_cmd_step <= 1'b0;
		else if (cmd_hi && i_cmd.data[STEP_BIT])
			o_cmd_step <= 1'b1;
		else if (!i_cpu_stall)
			o_cmd_step <= 1'b0;
	end

	// Needs halt set in the same word
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			o_cmd_clear_cache <= 1'b0;
		else if (cmd_hi && i_cmd.data[CLEAR_CACHE_BIT] && i_cmd.data[HALT_BIT])
			o_cmd_clear_cache <= 1'b1;
		else if (!i_cpu_stall)
			o_cmd_clear_cache <= 1'b0;
	end

	////////////////////////////////////////////////////////////
	// Status word
	////////////////////////////////////////////////////////////

	always_comb
	begin
		o_status = '0;
		o_status[16] = i_interrupt;
		o_status[14] = i_cpu_break;
		o_status[13:11] = i_cpu_cc;
		o_status[HALT_BIT] = o_cmd_halt;
		o_status[9] = !i_cpu_stall;
		// Interrupt pending, old position
		o_status[7] = i_interrupt;
		o_status[RESET_BIT] = o_cmd_reset;
	end

	// Core reports halted by dropping its stall
	assign o_halted = !i_cpu_stall;

endmodule

/* logic/dbg_regbank.sv */
// CPU register bank as seen from the debug port: 32 words, one write
// port driven by the debug slave and one registered read port.
`timescale 1ns/1ps

module dbg_regbank
	import zip_dbg_pkg::*;
(
	input  logic		S_AXI_ACLK,
	// Write port, one-cycle strobe
	input  dbg_wr_t		i_wr,
	// Read port, data one cycle later
	input  reg_idx_t	i_ridx,
	output dbg_word_t	o_rdata
);

	localparam int NREGS = 2 ** $bits(reg_idx_t);

	// Storage only, no reset
	dbg_word_t	mem [0:NREGS-1];

	////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_wr.valid)
			mem[i_wr.idx] <= i_wr.data;
	end

	////////////////////////////////////////////////////////////
	// Read port
	////////////////////////////////////////////////////////////

	// Registered every cycle, the slave picks the right one
	always_ff @(posedge S_AXI_ACLK)
	begin
		o_rdata <= mem[i_ridx];
	end

endmodule

/* logic/zip_dbg_top.sv */
// Debug and control front end of the soft core: AXI-lite debug slave,
// core control and the debug register bank, wired together.
`timescale 1ns/1ps

module zip_dbg_top
	import zip_dbg_pkg::*;
#(
	parameter int	C_DBG_ADDR_WIDTH	= 8,
	parameter int	RESET_DURATION		= 10,
	parameter bit	START_HALTED		= 1'b0
)(
	input  logic				S_AXI_ACLK,
	input  logic				S_AXI_ARESETN,
	// AXI-lite debug port
	input  logic				S_DBG_AWVALID,
	output logic				S_DBG_AWREADY,
	input  logic [C_DBG_ADDR_WIDTH-1:0]	S_DBG_AWADDR,
	input  logic [2:0]			S_DBG_AWPROT,
	input  logic				S_DBG_WVALID,
	output logic				S_DBG_WREADY,
	input  dbg_word_t			S_DBG_WDATA,
	input  dbg_strb_t			S_DBG_WSTRB,
	output logic				S_DBG_BVALID,
	input  logic				S_DBG_BREADY,
	output logic [1:0]			S_DBG_BRESP,
	input  logic				S_DBG_ARVALID,
	output logic				S_DBG_ARREADY,
	input  logic [C_DBG_ADDR_WIDTH-1:0]	S_DBG_ARADDR,
	input  logic [2:0]			S_DBG_ARPROT,
	output logic				S_DBG_RVALID,
	input  logic				S_DBG_RREADY,
	output dbg_word_t			S_DBG_RDATA,
	output logic [1:0]			S_DBG_RRESP,
	// Core side
	input  logic				i_interrupt,
	input  logic				i_cpu_reset,
	input  logic				i_cpu_stall,
	input  logic				i_cpu_break,
	input  cpu_cc_t				i_cpu_cc,
	output logic				o_cmd_reset,
	output logic				o_cmd_halt,
	output logic				o_cmd_step,
	output logic				o_cmd_clear_cache,
	output logic				o_halted
);

	dbg_wr_t	reg_wr;
	dbg_cmd_t	cmd;
	reg_idx_t	reg_ridx;
	dbg_word_t	reg_rdata, status;
	logic		reg_wr_accept;

	dbg_axil_slave #(.C_DBG_ADDR_WIDTH(C_DBG_ADDR_WIDTH)) u_slave (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.S_DBG_AWVALID, .S_DBG_AWREADY, .S_DBG_AWADDR, .S_DBG_AWPROT,
		.S_DBG_WVALID, .S_DBG_WREADY, .S_DBG_WDATA, .S_DBG_WSTRB,
		.S_DBG_BVALID, .S_DBG_BREADY, .S_DBG_BRESP,
		.S_DBG_ARVALID, .S_DBG_ARREADY, .S_DBG_ARADDR, .S_DBG_ARPROT,
		.S_DBG_RVALID, .S_DBG_RREADY, .S_DBG_RDATA, .S_DBG_RRESP,
		.i_cpu_stall, .i_status(status), .i_reg_rdata(reg_rdata),
		.o_reg_ridx(reg_ridx), .o_reg_wr(reg_wr),
		.o_reg_wr_accept(reg_wr_accept), .o_cmd(cmd)
	);

	cpu_ctrl #(.RESET_DURATION(RESET_DURATION), .START_HALTED(START_HALTED)) u_ctrl (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_cmd(cmd), .i_reg_wr_accept(reg_wr_accept),
		.i_cpu_reset, .i_cpu_stall, .i_cpu_break, .i_interrupt, .i_cpu_cc,
		.o_status(status),
		.o_cmd_reset, .o_cmd_halt, .o_cmd_step, .o_cmd_clear_cache, .o_halted
	);

	dbg_regbank u_regbank (
		.S_AXI_ACLK,
		.i_wr(reg_wr), .i_ridx(reg_ridx), .o_rdata(reg_rdata)
	);

endmodule

/* sim/tb_model.svh */
// Testbench pieces included inside the testbench top: random numbers,
// the register and halt model, and AXI-lite master tasks on the DUT ports.
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

////////////////////////////////////////////////////////////
// Random numbers and model state
////////////////////////////////////////////////////////////

logic [31:0]	lcg_state = 32'd16836;
logic		stall_random = 1'b0;
int		wr_issued = 0;
int		rd_issued = 0;
// Last value written to each register, and whether one was written
dbg_word_t	reg_model [0:31];
logic		reg_known [0:31];
logic		exp_halt;

// Upper half only, low LCG bits repeat too soon
function automatic logic [15:0] rand_next();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state[31:16];
endfunction

// Status layout: reset 6, irq 7 and 16, running 9, halt 10, cc 13:11, break 14
function automatic dbg_word_t status_of(input logic halt, input logic rst);
	dbg_word_t s;
	s = '0;
	s[RESET_BIT] = rst;
	s[7] = i_interrupt;
	s[9] = !i_cpu_stall;
	s[HALT_BIT] = halt;
	s[13:11] = i_cpu_cc;
	s[14] = i_cpu_break;
	s[16] = i_interrupt;
	return s;
endfunction

////////////////////////////////////////////////////////////
// Bus tasks, entered and left on a falling edge
////////////////////////////////////////////////////////////

// Falling edge, new random stall when enabled
task automatic next_cycle();
	@(negedge S_AXI_ACLK);
	if (stall_random)
		i_cpu_stall = (rand_next() % 4) == 0;
endtask

// One write; rst_seen is o_cmd_reset when BVALID first shows
task automatic write_word(input logic [ADDR_W-1:0] addr, input dbg_word_t data,
	input dbg_strb_t strb, output logic rst_seen);
	logic	aw_go, w_go, b_go, b_seen;
	int	delay;
	rst_seen = 1'b0;
	b_seen = 1'b0;
	b_go = 1'b0;
	S_DBG_AWADDR = addr;
	S_DBG_WDATA = data;
	S_DBG_WSTRB = strb;
	S_DBG_AWVALID = 1'b1;
	S_DBG_WVALID = 1'b1;
	// Ready is registered, so it is stable here
	while (S_DBG_AWVALID || S_DBG_WVALID)
	begin
		aw_go = S_DBG_AWVALID && S_DBG_AWREADY;
		w_go = S_DBG_WVALID && S_DBG_WREADY;
		next_cycle();
		if (aw_go)
			S_DBG_AWVALID = 1'b0;
		if (w_go)
			S_DBG_WVALID = 1'b0;
	end
	wr_issued++;
	delay = rand_next() % 4;
	while (!b_go)
	begin
		if (S_DBG_BVALID)
		begin
			if (!b_seen)
				rst_seen = o_cmd_reset;
			b_seen = 1'b1;
			if (S_DBG_BRESP !== RESP_OKAY)
				flag_mismatch("S_DBG_BRESP", RESP_OKAY, S_DBG_BRESP);
			if (delay == 0)
				S_DBG_BREADY = 1'b1;
			else
				delay--;
		end
		b_go = S_DBG_BVALID && S_DBG_BREADY;
		next_cycle();
	end
	S_DBG_BREADY = 1'b0;
	if (S_DBG_BVALID)
		note_failure("second write response for a single write");
endtask

// One read; RDATA must not move while RVALID waits
task automatic read_word(input logic [ADDR_W-1:0] addr, output dbg_word_t data);
	logic		ar_go, r_go, held_valid;
	dbg_word_t	held;
	int		delay;
	held_valid = 1'b0;
	held = '0;
	r_go = 1'b0;
	S_DBG_ARADDR = addr;
	S_DBG_ARVALID = 1'b1;
	while (S_DBG_ARVALID)
	begin
		ar_go = S_DBG_ARREADY;
		next_cycle();
		if (ar_go)
			S_DBG_ARVALID = 1'b0;
	end
	rd_issued++;
	delay = rand_next() % 4;
	while (!r_go)
	begin
		if (S_DBG_RVALID)
		begin
			if (held_valid && S_DBG_RDATA !== held)
				flag_mismatch("S_DBG_RDATA held", held, S_DBG_RDATA);
			held = S_DBG_RDATA;
			held_valid = 1'b1;
			if (S_DBG_RRESP !== RESP_OKAY)
				flag_mismatch("S_DBG_RRESP", RESP_OKAY, S_DBG_RRESP);
			if (delay == 0)
				S_DBG_RREADY = 1'b1;
			else
				delay--;
		end
		r_go = S_DBG_RVALID && S_DBG_RREADY;
		next_cycle();
	end
	S_DBG_RREADY = 1'b0;
	data = held;
	if (S_DBG_RVALID)
		note_failure("second read response for a single read");
endtask

`endif

/* sim/tb_zip_dbg.sv */
// Testbench for the debug front end covering reset hold, register round trips
// under random stall, control commands, status word and back-pressure.
// Compile with list.f and run top module tb_zip_dbg.
`timescale 1ns/1ps

module tb_zip_dbg
	import zip_dbg_pkg::*;
;

	localparam int	ADDR_W		= 8;
	localparam int	RESET_DURATION	= 10;
	localparam bit	START_HALTED	= 1'b0;
	localparam int	CLK_PERIOD	= 100;
	localparam int	N_ROUNDS	= 200;
	// Round trips plus the command section
	localparam int	N_TRANS		= 2 * N_ROUNDS + 24;
	localparam int	WATCHDOG_CYCLES	= N_TRANS * 40 + 200;

	logic			S_AXI_ACLK, S_AXI_ARESETN;
	logic			S_DBG_AWVALID, S_DBG_AWREADY, S_DBG_WVALID, S_DBG_WREADY;
	logic [ADDR_W-1:0]	S_DBG_AWADDR, S_DBG_ARADDR;
	logic [2:0]		S_DBG_AWPROT, S_DBG_ARPROT;
	dbg_word_t		S_DBG_WDATA, S_DBG_RDATA;
	dbg_strb_t		S_DBG_WSTRB;
	logic			S_DBG_BVALID, S_DBG_BREADY, S_DBG_ARVALID, S_DBG_ARREADY;
	logic			S_DBG_RVALID, S_DBG_RREADY;
	logic [1:0]		S_DBG_BRESP, S_DBG_RRESP;
	logic			i_interrupt, i_cpu_reset, i_cpu_stall, i_cpu_break;
	cpu_cc_t		i_cpu_cc;
	logic			o_cmd_reset, o_cmd_halt, o_cmd_step, o_cmd_clear_cache, o_halted;
	int			err_value = 0;
	int			err_other = 0;
	int			b_count = 0;
	int			r_count = 0;

	zip_dbg_top uut (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.S_DBG_AWVALID, .S_DBG_AWREADY, .S_DBG_AWADDR, .S_DBG_AWPROT,
		.S_DBG_WVALID, .S_DBG_WREADY, .S_DBG_WDATA, .S_DBG_WSTRB,
		.S_DBG_BVALID, .S_DBG_BREADY, .S_DBG_BRESP,
		.S_DBG_ARVALID, .S_DBG_ARREADY, .S_DBG_ARADDR, .S_DBG_ARPROT,
		.S_DBG_RVALID, .S_DBG_RREADY, .S_DBG_RDATA, .S_DBG_RRESP,
		.i_interrupt, .i_cpu_reset, .i_cpu_stall, .i_cpu_break, .i_cpu_cc,
		.o_cmd_reset, .o_cmd_halt, .o_cmd_step, .o_cmd_clear_cache, .o_halted
	);

	task automatic flag_mismatch(input string name, input logic [31:0] expv,
		input logic [31:0] actv);
		$display("ERR time=%0t %s expected=%h actual=%h", $time, name, expv, actv);
		err_value++;
	endtask

	task automatic note_failure(input string what);
		$display("FAILURE at %0t: %s", $time, what);
		err_other++;
	endtask

	`include "tb_model.svh"

	// Fresh cc and irq held steady through the status read
	task automatic check_status();
		dbg_word_t	rdata, expv;
		i_cpu_cc = cpu_cc_t'(rand_next());
		i_interrupt = rand_next() > 16'h7fff;
		expv = status_of(exp_halt, 1'b0);
		read_word({1'b0, 5'(rand_next()), 2'b00}, rdata);
		if (rdata !== expv)
			flag_mismatch("S_DBG_RDATA status", expv, rdata);
		if (o_halted !== !i_cpu_stall)
			flag_mismatch("o_halted", !i_cpu_stall, o_halted);
	endtask

	// Control write to a random control address then halt and status checks
	task automatic send_command(input dbg_word_t data, input dbg_strb_t strb,
		input logic halt_after, output logic rst_seen);
		write_word({1'b0, 5'(rand_next()), 2'b00}, data, strb, rst_seen);
		exp_halt = halt_after;
		if (o_cmd_halt !== exp_halt)
			flag_mismatch("o_cmd_halt", exp_halt, o_cmd_halt);
		check_status();
	endtask

	////////////////////////////////////////////////////////////
	// Clock, watchdog, handshake counters
	////////////////////////////////////////////////////////////

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #(CLK_PERIOD / 2) S_AXI_ACLK = ~S_AXI_ACLK;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, sequence never finished", WATCHDOG_CYCLES);
		$display("Some tests failed");
		$finish;
	end

	// Count every response handshake against requests issued
	always @(posedge S_AXI_ACLK)
	begin
		if (S_DBG_BVALID && S_DBG_BREADY)
			b_count <= b_count + 1;
		if (S_DBG_RVALID && S_DBG_RREADY)
			r_count <= r_count + 1;
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial
	begin : main
		dbg_word_t	rdata, wdata;
		reg_idx_t	idx;
		logic		rst_seen;
		int		reset_cycles, n;
		S_AXI_ARESETN = 1'b0;
		S_DBG_AWVALID = 1'b0;
		S_DBG_AWADDR = '0;
		S_DBG_AWPROT = '0;
		S_DBG_WVALID = 1'b0;
		S_DBG_WDATA = '0;
		S_DBG_WSTRB = '0;
		S_DBG_BREADY = 1'b0;
		S_DBG_ARVALID = 1'b0;
		S_DBG_ARADDR = '0;
		S_DBG_ARPROT = '0;
		S_DBG_RREADY = 1'b0;
		i_interrupt = 1'b0;
		i_cpu_reset = 1'b0;
		i_cpu_stall = 1'b0;
		i_cpu_break = 1'b0;
		i_cpu_cc = '0;
		exp_halt = START_HALTED;
		for (n = 0; n < 32; n++)
			reg_known[n] = 1'b0;

		// Reset hold counted from the release edge
		repeat (2) @(posedge S_AXI_ACLK);
		next_cycle();
		S_AXI_ARESETN = 1'b1;
		if (S_DBG_BVALID !== 1'b0 || S_DBG_RVALID !== 1'b0)
			note_failure("response valid high straight after reset");
		if (o_cmd_halt !== START_HALTED)
			flag_mismatch("o_cmd_halt", START_HALTED, o_cmd_halt);
		if (o_cmd_step !== 1'b0)
			flag_mismatch("o_cmd_step", 0, o_cmd_step);
		if (o_cmd_clear_cache !== 1'b0)
			flag_mismatch("o_cmd_clear_cache", 0, o_cmd_clear_cache);
		reset_cycles = 0;
		while (o_cmd_reset === 1'b1 && reset_cycles <= 4 * RESET_DURATION)
		begin
			reset_cycles++;
			next_cycle();
		end
		if (reset_cycles != RESET_DURATION)
			flag_mismatch("o_cmd_reset cycles", RESET_DURATION, reset_cycles);

		// Register round trips with the core stalling at random
		stall_random = 1'b1;
		for (n = 0; n < N_ROUNDS; n++)
		begin
			idx = reg_idx_t'(rand_next());
			wdata[31:16] = rand_next();
			wdata[15:0] = rand_next();
			write_word({1'b1, idx, 2'b00}, wdata, 4'hf, rst_seen);
			reg_model[idx] = wdata;
			reg_known[idx] = 1'b1;
			idx = reg_idx_t'(rand_next());
			read_word({1'b1, idx, 2'b00}, rdata);
			if (reg_known[idx] && rdata !== reg_model[idx])
				flag_mismatch("S_DBG_RDATA", reg_model[idx], rdata);
		end
		// Register writes always leave the core halted
		exp_halt = 1'b1;
		if (o_cmd_halt !== exp_halt)
			flag_mismatch("o_cmd_halt", exp_halt, o_cmd_halt);

		// Commands with stall under direct control
		stall_random = 1'b0;
		i_cpu_stall = 1'b0;
		next_cycle();
		next_cycle();
		send_command(32'h0, 4'b0010, 1'b0, rst_seen);
		send_command(32'(1) << HALT_BIT, 4'b0010, 1'b1, rst_seen);
		send_command(32'h0, 4'b0010, 1'b0, rst_seen);
		send_command(32'(1) << RESET_BIT, 4'b0001, 1'b0, rst_seen);
		if (rst_seen !== 1'b1)
			flag_mismatch("o_cmd_reset", 1, rst_seen);
		// Step holds while the core stalls and halts once it runs a cycle
		i_cpu_stall = 1'b1;
		send_command(32'(1) << STEP_BIT, 4'b0010, 1'b0, rst_seen);
		if (o_cmd_step !== 1'b1)
			flag_mismatch("o_cmd_step", 1, o_cmd_step);
		i_cpu_stall = 1'b0;
		next_cycle();
		if (o_cmd_step !== 1'b0)
			flag_mismatch("o_cmd_step", 0, o_cmd_step);
		if (o_cmd_halt !== 1'b1)
			flag_mismatch("o_cmd_halt", 1, o_cmd_halt);
		exp_halt = 1'b1;
		send_command(32'h0, 4'b0010, 1'b0, rst_seen);
		// Clear-cache with halt holds while stalled and ends halted
		i_cpu_stall = 1'b1;
		wdata = (32'(1) << HALT_BIT) | (32'(1) << CLEAR_CACHE_BIT);
		send_command(wdata, 4'b0010, 1'b1, rst_seen);
		if (o_cmd_clear_cache !== 1'b1)
			flag_mismatch("o_cmd_clear_cache", 1, o_cmd_clear_cache);
		i_cpu_stall = 1'b0;
		next_cycle();
		if (o_cmd_clear_cache !== 1'b0)
			flag_mismatch("o_cmd_clear_cache", 0, o_cmd_clear_cache);
		if (o_cmd_halt !== 1'b1)
			flag_mismatch("o_cmd_halt", 1, o_cmd_halt);
		send_command(32'h0, 4'b0010, 1'b0, rst_seen);
		// Register write while running
		idx = reg_idx_t'(rand_next());
		wdata[31:16] = rand_next();
		wdata[15:0] = rand_next();
		write_word({1'b1, idx, 2'b00}, wdata, 4'hf, rst_seen);
		reg_model[idx] = wdata;
		exp_halt = 1'b1;
		if (o_cmd_halt !== exp_halt)
			flag_mismatch("o_cmd_halt", exp_halt, o_cmd_halt);
		read_word({1'b1, idx, 2'b00}, rdata);
		if (rdata !== reg_model[idx])
			flag_mismatch("S_DBG_RDATA", reg_model[idx], rdata);
		check_status();

		// One response per request
		next_cycle();
		if (b_count != wr_issued)
			note_failure($sformatf("%0d writes issued, %0d write responses",
				wr_issued, b_count));
		if (r_count != rd_issued)
			note_failure($sformatf("%0d reads issued, %0d read responses",
				rd_issued, r_count));

		$display("Checks done: %0d value errors, %0d other errors", err_value, err_other);
		if (err_value + err_other == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* list.f */
+incdir+sim
logic/zip_dbg_pkg.sv
logic/dbg_skid.sv
logic/dbg_axil_slave.sv
logic/cpu_ctrl.sv
logic/dbg_regbank.sv
logic/zip_dbg_top.sv
sim/tb_zip_dbg.sv
